// File: Makefile
TOP := msi_ptw_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the Verilator simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: dv/msi_ptw_properties.sv
`timescale 1ns/10ps

module msi_ptw_properties (
    input logic                     clk_i,
    input logic                     rst_ni,
    input msi_ptw_pkg::mem_rd_req_t mem_req_i,
    input msi_ptw_pkg::mem_rd_rsp_t mem_rsp_i,
    input logic                     iotlb_update_i,
    input logic                     mrifc_update_i,
    input logic                     ignore_i,
    input logic                     error_i,
    input msi_ptw_pkg::cause_t      cause_i
);

    // Read address held, unchanged, until accepted
    ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_i.ar_valid && !mem_rsp_i.ar_ready)
            |=> (mem_req_i.ar_valid && $stable(mem_req_i.ar_addr)))
        else $error("ar_valid dropped or ar_addr changed before the handshake");

    // IOTLB and MRIF cache never written together
    update_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(iotlb_update_i && mrifc_update_i))
        else $error("IOTLB and MRIF cache updates in the same cycle");

    // A fault always carries a cause
    cause_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
        error_i |-> (cause_i != '0))
        else $error("error_o high with a zero cause");

    // Quiet outputs right after reset
    reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !(mem_req_i.ar_valid || iotlb_update_i || mrifc_update_i
                            || ignore_i || error_i))
        else $error("Result output active in the first cycle after reset");

endmodule

// File: dv/msi_ptw_tb.sv
`timescale 1ns/10ps

module msi_ptw_tb;

    import msi_ptw_pkg::*;

    localparam int NUM_REQS   = 300;
    localparam int TIMEOUT    = 100;
    // Result kinds of one request
    localparam int RES_IOTLB  = 0;
    localparam int RES_MRIFC  = 1;
    localparam int RES_IGNORE = 2;
    localparam int RES_ERROR  = 3;

    logic          clk_i;
    logic          rst_ni;
    logic          init_msi_trans;
    logic          is_rx;
    gppn_t         gppn;
    page_offset_t  req_offset;
    ppn_t          msiptp_ppn;
    msi_mask_t     msi_addr_mask;
    mem_rd_rsp_t   mem_rsp;
    mem_rd_req_t   mem_req;
    logic          iotlb_update;
    msi_pte_flat_t iotlb_content;
    logic          mrifc_update;
    mrifc_entry_t  mrifc_content;
    logic          ignore;
    logic          error;
    cause_t        cause;

    // Current request and its PTE doublewords
    logic          is_rx_v;
    gppn_t         gppn_v;
    msi_mask_t     mask_v;
    ppn_t          ppn_v;
    page_offset_t  offset_v;
    dword_t        beat0, beat1;
    axi_resp_t     resp0, resp1;
    // Reference model outputs
    paddr_t        exp_addr;
    int            exp_kind;
    cause_t        exp_cause;
    msi_pte_flat_t exp_flat;
    mrifc_entry_t  exp_mrifc;

    msi_ptw_top UUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .init_msi_trans_i (init_msi_trans),
        .is_rx_i          (is_rx),
        .gppn_i           (gppn),
        .req_offset_i     (req_offset),
        .msiptp_ppn_i     (msiptp_ppn),
        .msi_addr_mask_i  (msi_addr_mask),
        .mem_rsp_i        (mem_rsp),
        .mem_req_o        (mem_req),
        .iotlb_update_o   (iotlb_update),
        .iotlb_content_o  (iotlb_content),
        .mrifc_update_o   (mrifc_update),
        .mrifc_content_o  (mrifc_content),
        .ignore_o         (ignore),
        .error_o          (error),
        .cause_o          (cause)
    );

    bind msi_ptw_top msi_ptw_properties u_properties (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .mem_req_i      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i),
        .iotlb_update_i (iotlb_update_o),
        .mrifc_update_i (mrifc_update_o),
        .ignore_i       (ignore_o),
        .error_i        (error_o),
        .cause_i        (cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %0t %s expected %0b got %0b", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_addr(string name, paddr_t got, paddr_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_flat(string name, msi_pte_flat_t got, msi_pte_flat_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_mrifc(string name, mrifc_entry_t got, mrifc_entry_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_cause(string name, cause_t got, cause_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s expected %0d got %0d", $time, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_result_kind(int n, int got);
        if (got != exp_kind) begin
            $display("Request %0d ended with result kind %0d instead of %0d", n, got, exp_kind);
            stop_on_error();
        end
    endtask

    function automatic dword_t random_dword();
        return {$urandom, $urandom};
    endfunction

    // Each masked bit lands at the count of set mask bits below it
    function automatic msi_mask_t gather_index(gppn_t g, msi_mask_t m);
        msi_mask_t idx;
        msi_mask_t below;
        idx = '0;
        for (int b = 0; b < 12; b++) begin
            below = m & ((12'd1 << b) - 12'd1);
            if (m[b]) idx[$countones(below)] = g[b];
        end
        return idx;
    endfunction

    task automatic pick_request();
        dword_t r;
        int     m;
        is_rx_v  = ($urandom_range(0, 9) == 0);
        r        = random_dword();
        gppn_v   = r[43:0];
        mask_v   = r[55:44];
        r        = random_dword();
        ppn_v    = r[43:0];
        offset_v = ($urandom_range(0, 3) == 0) ? 12'($urandom_range(1, 4095)) : '0;
        beat0    = random_dword();
        // Mostly valid with the custom bit rarely set
        beat0[0]  = ($urandom_range(0, 7) != 0);
        beat0[63] = ($urandom_range(0, 7) == 0);
        m         = $urandom_range(0, 9);
        if (m < 4) beat0[2:1] = 2'd3;
        else if (m < 8) beat0[2:1] = 2'd1;
        else if (m == 8) beat0[2:1] = 2'd0;
        else beat0[2:1] = 2'd2;
        // Reserved fields mostly clean for the chosen layout
        if ($urandom_range(0, 5) != 0) begin
            beat0[62:54] = '0;
            if (beat0[2:1] == 2'd3) beat0[9:3] = '0;
            else beat0[6:3] = '0;
        end
        beat1 = random_dword();
        if ($urandom_range(0, 5) != 0) begin
            beat1[59:54] = '0;
            beat1[63:61] = '0;
        end
        resp0 = ($urandom_range(0, 7) == 0) ? 2'($urandom_range(1, 3)) : 2'b00;
        resp1 = ($urandom_range(0, 7) == 0) ? 2'($urandom_range(1, 3)) : 2'b00;
    endtask

    // Expected address and result straight from the PTE bit layout
    task automatic predict_result();
        msi_mask_t idx;
        idx               = gather_index(gppn_v, mask_v);
        exp_addr          = {ppn_v, 12'h000};
        exp_addr[15:4]    = exp_addr[15:4] | idx;
        exp_flat          = msi_pte_flat_t'(beat0);
        exp_mrifc         = {beat0[53:7], beat1[60], beat1[9:0], beat1[53:10]};
        exp_kind          = RES_ERROR;
        exp_cause         = '0;
        if (is_rx_v) exp_cause = 12'd1;
        else if (!beat0[0] || beat0[63]) exp_cause = 12'd262;
        else if (resp0 != 2'b00) exp_cause = 12'd270;
        else if (beat0[2:1] == 2'd3) begin
            if ((|beat0[9:3]) || (|beat0[62:54])) exp_cause = 12'd263;
            else exp_kind = RES_IOTLB;
        end else if (beat0[2:1] == 2'd1) begin
            if ((|beat0[6:3]) || (|beat0[62:54])) exp_cause = 12'd263;
            else if (|offset_v) exp_kind = RES_IGNORE;
            else if (resp1 != 2'b00) exp_cause = 12'd270;
            else if ((|beat1[59:54]) || (|beat1[63:61])) exp_cause = 12'd263;
            else exp_kind = RES_MRIFC;
        end else exp_cause = 12'd263;
    endtask

    task automatic run_request(int n);
        int   cycles;
        int   ar_wait;
        int   gap;
        int   beats;
        int   results;
        logic addr_phase;
        logic err_prev;
        logic burst_done;
        logic done;
        logic nxt_ready;
        logic nxt_valid;
        cycles     = 0;
        ar_wait    = $urandom_range(0, 3);
        gap        = $urandom_range(0, 2);
        beats      = 0;
        results    = 0;
        addr_phase = 1'b1;
        err_prev   = 1'b0;
        // No burst expected for read-for-execute
        burst_done = is_rx_v;
        done       = 1'b0;
        @(posedge clk_i);
        init_msi_trans <= 1'b1;
        is_rx          <= is_rx_v;
        gppn           <= gppn_v;
        msi_addr_mask  <= mask_v;
        msiptp_ppn     <= ppn_v;
        req_offset     <= offset_v;
        @(posedge clk_i);
        init_msi_trans <= 1'b0;
        while (!done) begin
            @(negedge clk_i);
            cycles = cycles + 1;
            if (cycles > TIMEOUT) begin
                $display("Request %0d did not finish within %0d cycles", n, TIMEOUT);
                stop_on_error();
            end
            // First cycle after the strobe was taken
            if (cycles == 1) begin
                check_flag("ar_valid", mem_req.ar_valid, !is_rx_v);
                check_flag("error_o", error, is_rx_v);
            end
            if (iotlb_update) begin
                results = results + 1;
                check_result_kind(n, RES_IOTLB);
                check_flat("iotlb_content_o", iotlb_content, exp_flat);
            end
            if (mrifc_update) begin
                results = results + 1;
                check_result_kind(n, RES_MRIFC);
                check_mrifc("mrifc_content_o", mrifc_content, exp_mrifc);
            end
            if (ignore) begin
                results = results + 1;
                check_result_kind(n, RES_IGNORE);
            end
            // Error counts once however long it stays high
            if (error) begin
                if (!err_prev) begin
                    results = results + 1;
                    check_result_kind(n, RES_ERROR);
                end
                check_cause("cause_o", cause, exp_cause);
            end
            err_prev = error;
            if (results > 1) begin
                $display("Request %0d produced more than one result", n);
                stop_on_error();
            end
            if (!addr_phase && mem_req.ar_valid) begin
                $display("Request %0d issued a second memory read", n);
                stop_on_error();
            end
            // Memory model picks the values for the next edge
            nxt_ready = 1'b0;
            nxt_valid = 1'b0;
            if (addr_phase) begin
                if (mem_req.ar_valid && is_rx_v) begin
                    $display("Read-for-execute request %0d issued a memory read", n);
                    stop_on_error();
                end
                if (mem_req.ar_valid && mem_rsp.ar_ready) begin
                    // Handshake on the coming edge
                    check_addr("ar_addr", mem_req.ar_addr, exp_addr);
                    addr_phase = 1'b0;
                end else if (mem_req.ar_valid) begin
                    if (ar_wait == 0) nxt_ready = 1'b1;
                    else ar_wait = ar_wait - 1;
                end
            end else if (beats < 2) begin
                if (gap == 0) begin
                    nxt_valid = 1'b1;
                    beats     = beats + 1;
                    gap       = $urandom_range(0, 2);
                end else begin
                    gap = gap - 1;
                end
            end else if (!mem_rsp.r_valid) begin
                burst_done = 1'b1;
            end
            done = (results == 1) && burst_done && !error;
            @(posedge clk_i);
            mem_rsp.ar_ready <= nxt_ready;
            mem_rsp.r_valid  <= nxt_valid;
            mem_rsp.r_data   <= (beats == 1) ? beat0 : beat1;
            mem_rsp.r_resp   <= (beats == 1) ? resp0 : resp1;
            mem_rsp.r_last   <= nxt_valid && (beats == 2);
        end
    endtask

    initial begin
        void'($urandom(42));
        rst_ni         <= 1'b0;
        init_msi_trans <= 1'b0;
        is_rx          <= 1'b0;
        gppn           <= '0;
        req_offset     <= '0;
        msiptp_ppn     <= '0;
        msi_addr_mask  <= '0;
        mem_rsp        <= '0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int n = 0; n < NUM_REQS; n++) begin
            pick_request();
            predict_result();
            run_request(n);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// File: filelist.f
src/msi_ptw_pkg.sv
src/msi_pte_addr_gen.sv
src/msi_flat_walker.sv
src/msi_mrif_walker.sv
src/msi_ptw_top.sv
dv/msi_ptw_properties.sv
dv/msi_ptw_tb.sv

// File: src/msi_flat_walker.sv
`timescale 1ns/10ps

module msi_flat_walker (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       init_msi_trans_i,
    input  logic                       is_rx_i,
    input  msi_ptw_pkg::paddr_t        pte_addr_i,
    input  msi_ptw_pkg::mem_rd_rsp_t   mem_rsp_i,
    output msi_ptw_pkg::mem_rd_req_t   mem_req_o,
    input  msi_ptw_pkg::fault_t        mrif_fault_i,
    output logic                       init_mrif_o,
    output logic                       iotlb_update_o,
    output msi_ptw_pkg::msi_pte_flat_t iotlb_content_o,
    output logic                       error_o,
    output msi_ptw_pkg::cause_t        cause_o
);

    import msi_ptw_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        FLAT_ERROR
    } flat_state_t;

    flat_state_t   state_q, state_d;
    // MSI PTE address, captured at the strobe
    paddr_t        pptr_q, pptr_d;
    cause_t        cause_q, cause_d;
    // Second beat still due while in error
    logic          wait_last_q, wait_last_d;
    // First beat seen as a flat PTE
    msi_pte_flat_t pte_flat;

    assign pte_flat        = msi_pte_flat_t'(mem_rsp_i.r_data);
    assign iotlb_content_o = pte_flat;

    // Address held stable while waiting for ready
    assign mem_req_o.ar_addr = pptr_q;

    always_comb begin
        state_d            = state_q;
        pptr_d             = pptr_q;
        cause_d            = cause_q;
        wait_last_d        = wait_last_q;
        mem_req_o.ar_valid = 1'b0;
        init_mrif_o        = 1'b0;
        iotlb_update_o     = 1'b0;

        case (state_q)
            IDLE: begin
                wait_last_d = 1'b0;
                if (init_msi_trans_i) begin
                    // Read-for-execute faults with no memory access
                    if (is_rx_i) begin
                        cause_d = CAUSE_INSTR_ACCESS;
                        state_d = FLAT_ERROR;
                    end else begin
                        pptr_d  = pte_addr_i;
                        state_d = MEM_ACCESS;
                    end
                end
            end

            MEM_ACCESS: begin
                mem_req_o.ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_d = PROC_PTE;
                end
            end

            // First beat decides the outcome
            PROC_PTE: begin
                if (mem_rsp_i.r_valid) begin
                    // Any fault here still has the second beat to drain
                    wait_last_d = 1'b1;
                    // Invalid or custom-format PTE wins over a bad response
                    if (!pte_flat.v || pte_flat.c) begin
                        cause_d = CAUSE_PTE_INVALID;
                        state_d = FLAT_ERROR;
                    end else if (mem_rsp_i.r_resp != RESP_OKAY) begin
                        cause_d = CAUSE_PT_CORRUPT;
                        state_d = FLAT_ERROR;
                    end else begin
                        case (pte_flat.m)
                            // Hand over to the MRIF walker
                            MODE_MRIF: begin
                                init_mrif_o = 1'b1;
                                wait_last_d = 1'b0;
                                state_d     = IDLE;
                            end
                            MODE_FLAT: begin
                                if ((|pte_flat.rsv_1) || (|pte_flat.rsv_2)) begin
                                    cause_d = CAUSE_PTE_MISCONF;
                                    state_d = FLAT_ERROR;
                                end else begin
                                    iotlb_update_o = 1'b1;
                                    wait_last_d    = 1'b0;
                                    state_d        = IDLE;
                                end
                            end
                            // Reserved modes
                            default: begin
                                cause_d = CAUSE_PTE_MISCONF;
                                state_d = FLAT_ERROR;
                            end
                        endcase
                    end
                end
            end

            // Hold the fault until the burst is over
            FLAT_ERROR: begin
                if (!wait_last_q || (mem_rsp_i.r_valid && mem_rsp_i.r_last)) begin
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            cause_q     <= '0;
            wait_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cause_q     <= cause_d;
            wait_last_q <= wait_last_d;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_d;
    end

    // Own fault first, else the MRIF walker's
    assign error_o = (state_q == FLAT_ERROR) || mrif_fault_i.error;
    assign cause_o = (state_q == FLAT_ERROR) ? cause_q : mrif_fault_i.cause;

endmodule

// File: src/msi_mrif_walker.sv
`timescale 1ns/10ps

module msi_mrif_walker (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      init_mrif_i,
    input  msi_ptw_pkg::page_offset_t req_offset_i,
    input  msi_ptw_pkg::mem_rd_rsp_t  mem_rsp_i,
    output logic                      ignore_o,
    output logic                      mrifc_update_o,
    output msi_ptw_pkg::mrifc_entry_t mrifc_content_o,
    output msi_ptw_pkg::fault_t       fault_o
);

    import msi_ptw_pkg::*;

    typedef enum logic [1:0] {
        MRIF_IDLE,
        NOTICE_PTE,
        MRIF_ERROR
    } mrif_state_t;

    mrif_state_t     state_q, state_d;
    // MRIF address from the first beat
    mrif_addr_t      addr_q, addr_d;
    cause_t          cause_q, cause_d;
    logic            wait_last_q, wait_last_d;
    // Current beat seen in both layouts
    msi_pte_mrif_t   pte_mrif;
    msi_pte_notice_t pte_notice;

    assign pte_mrif   = msi_pte_mrif_t'(mem_rsp_i.r_data);
    assign pte_notice = msi_pte_notice_t'(mem_rsp_i.r_data);

    // Entry built from the stored address and the second beat
    assign mrifc_content_o.addr = addr_q;
    assign mrifc_content_o.nid  = {pte_notice.nid_10, pte_notice.nid_9_0};
    assign mrifc_content_o.nppn = pte_notice.nppn;

    always_comb begin
        state_d        = state_q;
        addr_d         = addr_q;
        cause_d        = cause_q;
        wait_last_d    = wait_last_q;
        ignore_o       = 1'b0;
        mrifc_update_o = 1'b0;

        case (state_q)
            // Trigger arrives with the first beat on the bus
            MRIF_IDLE: begin
                wait_last_d = 1'b0;
                if (init_mrif_i) begin
                    if ((|pte_mrif.rsv_1) || (|pte_mrif.rsv_2)) begin
                        cause_d     = CAUSE_PTE_MISCONF;
                        wait_last_d = 1'b1;
                        state_d     = MRIF_ERROR;
                    end else if (|req_offset_i) begin
                        // Only whole-register writes, drop silently
                        ignore_o = 1'b1;
                    end else begin
                        addr_d  = pte_mrif.addr;
                        state_d = NOTICE_PTE;
                    end
                end
            end

            // Second beat, response checked before layout
            NOTICE_PTE: begin
                if (mem_rsp_i.r_valid) begin
                    if (mem_rsp_i.r_resp != RESP_OKAY) begin
                        cause_d     = CAUSE_PT_CORRUPT;
                        wait_last_d = !mem_rsp_i.r_last;
                        state_d     = MRIF_ERROR;
                    end else if ((|pte_notice.rsv_1) || (|pte_notice.rsv_2)) begin
                        cause_d     = CAUSE_PTE_MISCONF;
                        wait_last_d = !mem_rsp_i.r_last;
                        state_d     = MRIF_ERROR;
                    end else begin
                        mrifc_update_o = 1'b1;
                        state_d        = MRIF_IDLE;
                    end
                end
            end

            // Fault held until the last beat is gone
            MRIF_ERROR: begin
                if (!wait_last_q || (mem_rsp_i.r_valid && mem_rsp_i.r_last)) begin
                    state_d = MRIF_IDLE;
                end
            end

            default: state_d = MRIF_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= MRIF_IDLE;
            cause_q     <= '0;
            wait_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cause_q     <= cause_d;
            wait_last_q <= wait_last_d;
        end
    end

    always_ff @(posedge clk_i) begin
        addr_q <= addr_d;
    end

    // Cause reads zero outside the error state
    assign fault_o.error = (state_q == MRIF_ERROR);
    assign fault_o.cause = (state_q == MRIF_ERROR) ? cause_q : '0;

endmodule

// File: src/msi_pte_addr_gen.sv
`timescale 1ns/10ps

module msi_pte_addr_gen (
    input  msi_ptw_pkg::gppn_t     gppn_i,
    input  msi_ptw_pkg::msi_mask_t msi_addr_mask_i,
    input  msi_ptw_pkg::ppn_t      msiptp_ppn_i,
    output msi_ptw_pkg::paddr_t    pte_addr_o
);

    import msi_ptw_pkg::*;

    // Dense interrupt-file index
    msi_mask_t   if_index;
    // Next free position in the index
    int unsigned pack_pos;

    // Gather page-number bits under the mask, lowest first
    always_comb begin
        if_index = '0;
        pack_pos = 0;
        for (int i = 0; i < MSI_MASK_W; i++) begin
            if (msi_addr_mask_i[i]) begin
                if_index[pack_pos] = gppn_i[i];
                pack_pos           = pack_pos + 1;
            end
        end
    end

    // Table base on a page boundary
    // Each MSI PTE takes 16 bytes
    assign pte_addr_o = {msiptp_ppn_i, 12'b0} | (paddr_t'(if_index) << 4);

endmodule

// File: src/msi_ptw_pkg.sv
package msi_ptw_pkg;

    // Address and page widths
    localparam int unsigned PLEN       = 56;
    localparam int unsigned PPN_W      = 44;
    localparam int unsigned GPPN_W     = 44;
    // Mask width, also the width of the gathered interrupt-file index
    localparam int unsigned MSI_MASK_W = 12;
    localparam int unsigned CAUSE_W    = 12;

    // Vectors with a meaning
    typedef logic [PLEN-1:0]       paddr_t;
    typedef logic [PPN_W-1:0]      ppn_t;
    typedef logic [GPPN_W-1:0]     gppn_t;
    typedef logic [MSI_MASK_W-1:0] msi_mask_t;
    typedef logic [11:0]           page_offset_t;
    typedef logic [63:0]           dword_t;
    typedef logic [CAUSE_W-1:0]    cause_t;
    // MRIF address bits 53 to 7
    typedef logic [46:0]           mrif_addr_t;
    typedef logic [10:0]           nid_t;
    typedef logic [1:0]            axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // Fault causes
    localparam cause_t CAUSE_INSTR_ACCESS = 12'd1;
    localparam cause_t CAUSE_PTE_INVALID  = 12'd262;
    localparam cause_t CAUSE_PTE_MISCONF  = 12'd263;
    localparam cause_t CAUSE_PT_CORRUPT   = 12'd270;

    // MSI PTE modes, 0 and 2 reserved
    localparam logic [1:0] MODE_MRIF = 2'd1;
    localparam logic [1:0] MODE_FLAT = 2'd3;

    // First doubleword, flat mode
    typedef struct packed {
        logic       c;
        logic [8:0] rsv_2;
        ppn_t       ppn;
        logic [6:0] rsv_1;
        logic [1:0] m;
        logic       v;
    } msi_pte_flat_t;

    // First doubleword, MRIF mode
    typedef struct packed {
        logic       c;
        logic [8:0] rsv_2;
        mrif_addr_t addr;
        logic [3:0] rsv_1;
        logic [1:0] m;
        logic       v;
    } msi_pte_mrif_t;

    // Second doubleword, notice info for MRIF mode
    typedef struct packed {
        logic [2:0] rsv_2;
        logic       nid_10;
        logic [5:0] rsv_1;
        ppn_t       nppn;
        logic [9:0] nid_9_0;
    } msi_pte_notice_t;

    // Read-only memory port, request side
    typedef struct packed {
        logic   ar_valid;
        paddr_t ar_addr;
    } mem_rd_req_t;

    // Read-only memory port, response side
    typedef struct packed {
        logic      ar_ready;
        logic      r_valid;
        dword_t    r_data;
        axi_resp_t r_resp;
        logic      r_last;
    } mem_rd_rsp_t;

    // MRIF cache entry
    typedef struct packed {
        mrif_addr_t addr;
        nid_t       nid;
        ppn_t       nppn;
    } mrifc_entry_t;

    // Fault level with its cause
    typedef struct packed {
        logic   error;
        cause_t cause;
    } fault_t;

endpackage

// File: src/msi_ptw_top.sv
`timescale 1ns/10ps

module msi_ptw_top (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       init_msi_trans_i,
    input  logic                       is_rx_i,
    input  msi_ptw_pkg::gppn_t         gppn_i,
    input  msi_ptw_pkg::page_offset_t  req_offset_i,
    input  msi_ptw_pkg::ppn_t          msiptp_ppn_i,
    input  msi_ptw_pkg::msi_mask_t     msi_addr_mask_i,
    input  msi_ptw_pkg::mem_rd_rsp_t   mem_rsp_i,
    output msi_ptw_pkg::mem_rd_req_t   mem_req_o,
    output logic                       iotlb_update_o,
    output msi_ptw_pkg::msi_pte_flat_t iotlb_content_o,
    output logic                       mrifc_update_o,
    output msi_ptw_pkg::mrifc_entry_t  mrifc_content_o,
    output logic                       ignore_o,
    output logic                       error_o,
    output msi_ptw_pkg::cause_t        cause_o
);

    import msi_ptw_pkg::*;

    // MSI PTE address from the request fields
    paddr_t pte_addr;
    // Flat to MRIF handover
    logic   init_mrif;
    // MRIF fault merged by the flat walker
    fault_t mrif_fault;

    msi_pte_addr_gen u_addr_gen (
        .gppn_i          (gppn_i),
        .msi_addr_mask_i (msi_addr_mask_i),
        .msiptp_ppn_i    (msiptp_ppn_i),
        .pte_addr_o      (pte_addr)
    );

    msi_flat_walker u_flat_walker (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .init_msi_trans_i (init_msi_trans_i),
        .is_rx_i          (is_rx_i),
        .pte_addr_i       (pte_addr),
        .mem_rsp_i        (mem_rsp_i),
        .mem_req_o        (mem_req_o),
        .mrif_fault_i     (mrif_fault),
        .init_mrif_o      (init_mrif),
        .iotlb_update_o   (iotlb_update_o),
        .iotlb_content_o  (iotlb_content_o),
        .error_o          (error_o),
        .cause_o          (cause_o)
    );

    // Only observes read data, never drives the port
    msi_mrif_walker u_mrif_walker (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .init_mrif_i     (init_mrif),
        .req_offset_i    (req_offset_i),
        .mem_rsp_i       (mem_rsp_i),
        .ignore_o        (ignore_o),
        .mrifc_update_o  (mrifc_update_o),
        .mrifc_content_o (mrifc_content_o),
        .fault_o         (mrif_fault)
    );

endmodule
